//--- sim.f
+incdir+design
design/package_data_pkg.sv
design/package_data_if.sv
design/block_buffer.sv
design/sample_packer.sv
design/cpri_writer.sv
design/package_data_top.sv
dv/tb_package_data.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir
FAIL_MSG="Test FAILED"

verilator --binary --timing --assert -f sim.f --top-module tb_package_data \
    -Mdir "$BUILD_DIR" -o sim_tb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

"./$BUILD_DIR/sim_tb" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "$FAIL_MSG" "$LOG"; then
    exit 1
fi
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi
exit 0

//--- dv/tb_package_data.sv
`timescale 1ns/1ns
`include "package_data_defs.svh"

module tb_package_data;
    import package_data_pkg::*;

    localparam int CLK_PERIOD      = 40;
    localparam int RESET_CYCLES    = 4;
    localparam int MAX_BLOCKS      = 3;
    // five tests of up to three blocks, about 200 cycles per block
    localparam int TIMEOUT_CYCLES  = 5 * MAX_BLOCKS * 200;
    localparam int LANES_PER_GROUP = `GROUP_BEATS - 1;
    localparam int UPPER_SLOT_OFS  = `DATA_ADDR_LAST - `DATA_ADDR_FIRST + 1;

    logic                         clk = 1'b0;
    logic                         rst;
    logic                         i_valid;
    logic                         i_sop;
    logic                         i_eop;
    logic [`SAMPLE_W-1:0]         i_ant0_data;
    logic [`SAMPLE_W-1:0]         i_ant1_data;
    logic [`SAMPLE_W-1:0]         i_ant2_data;
    logic [`SAMPLE_W-1:0]         i_ant3_data;
    logic [3:0]                   i_ch_type;
    logic                         i_cell_idx;
    logic [6:0]                   i_slot_idx;
    logic [3:0]                   i_sym_idx;
    logic [8:0]                   i_prb_idx;
    logic [`NUM_ANT*`SHIFT_W-1:0] i_shift;
    logic                         o_ready;
    logic                         o_cpri_wen;
    logic [`BEAT_IDX_W-1:0]       o_cpri_waddr;
    logic [`WORD_W-1:0]           o_cpri_wdata;
    logic                         o_cpri_wlast;

    // stimulus and expected images of the blocks in the current test
    logic [`SAMPLE_W-1:0] blk_samples [MAX_BLOCKS][`BLOCK_BEATS][`NUM_ANT];
    block_header_t        blk_header [MAX_BLOCKS];

    // writes seen on the cpri port
    logic [`BEAT_IDX_W-1:0] wr_addr_q [$];
    logic [`WORD_W-1:0]     wr_data_q [$];
    logic                   wr_last_q [$];
    int                     wr_cycle_q [$];

    integer seed = 32'h4cdc;
    int     cycle_cnt = 0;
    int     total_writes = 0;
    int     blocks_in = 0;
    int     stall_cnt = 0;

    package_data_top uut
    (
        .clk          (clk),
        .rst          (rst),
        .i_valid      (i_valid),
        .o_ready      (o_ready),
        .i_sop        (i_sop),
        .i_eop        (i_eop),
        .i_ant0_data  (i_ant0_data),
        .i_ant1_data  (i_ant1_data),
        .i_ant2_data  (i_ant2_data),
        .i_ant3_data  (i_ant3_data),
        .i_ch_type    (i_ch_type),
        .i_cell_idx   (i_cell_idx),
        .i_slot_idx   (i_slot_idx),
        .i_sym_idx    (i_sym_idx),
        .i_prb_idx    (i_prb_idx),
        .i_shift      (i_shift),
        .o_cpri_wen   (o_cpri_wen),
        .o_cpri_waddr (o_cpri_waddr),
        .o_cpri_wdata (o_cpri_wdata),
        .o_cpri_wlast (o_cpri_wlast)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES)
            report_error($sformatf("timeout: run not finished after %0d cycles", cycle_cnt));
    end

    // outputs are registered, so they are settled at the falling edge
    always @(negedge clk)
    begin
        if (!rst && o_cpri_wen)
        begin
            wr_addr_q.push_back(o_cpri_waddr);
            wr_data_q.push_back(o_cpri_wdata);
            wr_last_q.push_back(o_cpri_wlast);
            wr_cycle_q.push_back(cycle_cnt);
            total_writes++;
        end
    end

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string test_name, input string what,
                               input logic [63:0] expected, input logic [63:0] actual);
        assert (expected === actual)
        else
            report_error($sformatf("[FAIL] %s %s: expected %h, actual %h",
                                   test_name, what, expected, actual));
    endtask

    // ----------------------------------------------------------------------
    // reference model of one 96-word buffer image
    // ----------------------------------------------------------------------

    function automatic logic [63:0] expected_word(input int blk, input int addr);
        logic [`GROUP_BEATS*`SAMPLE_W-1:0] concat;
        logic [63:0]                       word;
        int                                grp;
        int                                lane_idx;
        word = '0;
        // slot words below and above the data area
        if (addr < `DATA_ADDR_FIRST || addr > `DATA_ADDR_LAST)
        begin
            grp = (addr < `DATA_ADDR_FIRST) ? addr : addr - UPPER_SLOT_OFS;
            return (grp == `HEADER_SLOT) ? 64'(blk_header[blk]) : 64'(0);
        end
        grp      = (addr - `DATA_ADDR_FIRST) / LANES_PER_GROUP;
        lane_idx = (addr - `DATA_ADDR_FIRST) % LANES_PER_GROUP;
        for (int a = 0; a < `NUM_ANT; a++)
        begin
            for (int k = 0; k < `GROUP_BEATS; k++)
                concat[k*`SAMPLE_W +: `SAMPLE_W] = blk_samples[blk][grp*`GROUP_BEATS + k][a];
            word[a*`LANE_W +: `LANE_W] = concat[lane_idx*`LANE_W +: `LANE_W];
        end
        return word;
    endfunction

    task automatic make_block(input int blk, input bit ramp);
        block_header_t h;
        h          = '0;
        h.ch_type  = 4'($random(seed));
        h.cell_idx = 1'($random(seed));
        h.slot_idx = 7'($random(seed));
        h.sym_idx  = 4'(blk + 1);
        h.prb_idx  = 9'($random(seed));
        h.shift    = 16'($random(seed));
        blk_header[blk] = h;
        for (int beat = 0; beat < `BLOCK_BEATS; beat++)
            for (int a = 0; a < `NUM_ANT; a++)
                blk_samples[blk][beat][a] = ramp ? `SAMPLE_W'(beat * `NUM_ANT + a)
                                                 : `SAMPLE_W'($random(seed));
    endtask

    task automatic drive_header(input block_header_t h);
        i_ch_type  = h.ch_type;
        i_cell_idx = h.cell_idx;
        i_slot_idx = h.slot_idx;
        i_sym_idx  = h.sym_idx;
        i_prb_idx  = h.prb_idx;
        i_shift    = h.shift;
    endtask

    // ----------------------------------------------------------------------
    // drivers and checkers
    // ----------------------------------------------------------------------

    task automatic send_block(input int blk);
        for (int beat = 0; beat < `BLOCK_BEATS; beat++)
        begin
            i_valid     = 1'b1;
            i_sop       = (beat == 0);
            i_eop       = (beat == `BLOCK_BEATS - 1);
            i_ant0_data = blk_samples[blk][beat][0];
            i_ant1_data = blk_samples[blk][beat][1];
            i_ant2_data = blk_samples[blk][beat][2];
            i_ant3_data = blk_samples[blk][beat][3];
            // junk on the header inputs away from the first beat
            if (beat == 0)
                drive_header(blk_header[blk]);
            else
                drive_header(~blk_header[blk]);
            while (!o_ready)
            begin
                assert (blocks_in - total_writes / `BLOCK_BEATS >= 2)
                else
                    report_error("o_ready went low while fewer than two blocks were held");
                stall_cnt++;
                @(negedge clk);
            end
            @(negedge clk);
        end
        blocks_in++;
        i_valid = 1'b0;
        i_sop   = 1'b0;
        i_eop   = 1'b0;
    endtask

    task automatic clear_writes();
        wr_addr_q.delete();
        wr_data_q.delete();
        wr_last_q.delete();
        wr_cycle_q.delete();
    endtask

    task automatic wait_writes(input string test_name, input int count);
        while (wr_addr_q.size() < count)
            @(negedge clk);
        // no stray writes after the last block
        repeat (8) @(negedge clk);
        check_value(test_name, "write count", 64'(count), 64'(wr_addr_q.size()));
    endtask

    task automatic check_image(input string test_name, input int blk, input int base);
        logic [`BLOCK_BEATS-1:0] seen;
        int                      addr;
        seen = '0;
        for (int i = 0; i < `BLOCK_BEATS; i++)
        begin
            addr = int'(wr_addr_q[base + i]);
            assert (addr < `BLOCK_BEATS)
            else
                report_error($sformatf("%s: write to address %0d outside the buffer",
                                       test_name, addr));
            assert (!seen[addr])
            else
                report_error($sformatf("%s: address %0d written twice", test_name, addr));
            seen[addr] = 1'b1;
            check_value(test_name, $sformatf("data at address %0d", addr),
                        expected_word(blk, addr), wr_data_q[base + i]);
            check_value(test_name, $sformatf("wlast on write %0d", i),
                        64'(i == `BLOCK_BEATS - 1), 64'(wr_last_q[base + i]));
            if (i > 0)
                check_value(test_name, "cycles between writes", 64'(1),
                            64'(wr_cycle_q[base + i] - wr_cycle_q[base + i - 1]));
        end
    endtask

    // ----------------------------------------------------------------------
    // directed tests
    // ----------------------------------------------------------------------

    task automatic test_reset_state();
        check_value("reset_state", "o_cpri_wen", 64'(0), 64'(o_cpri_wen));
        check_value("reset_state", "o_cpri_wlast", 64'(0), 64'(o_cpri_wlast));
        check_value("reset_state", "o_ready", 64'(1), 64'(o_ready));
    endtask

    task automatic test_ramp_block();
        clear_writes();
        make_block(0, 1'b1);
        send_block(0);
        wait_writes("ramp_block", `BLOCK_BEATS);
        check_image("ramp_block", 0, 0);
    endtask

    task automatic test_header_slots();
        logic [63:0] head_model;
        head_model = {23'd0, 4'ha, 1'b1, 7'h55, 4'h9, 9'h1a5, 16'h3c5a};
        clear_writes();
        make_block(0, 1'b0);
        blk_header[0] = head_model;
        send_block(0);
        wait_writes("header_slots", `BLOCK_BEATS);
        for (int i = 0; i < `BLOCK_BEATS; i++)
            if (wr_addr_q[i] == `BEAT_IDX_W'(`HEADER_SLOT))
                check_value("header_slots", "header word", head_model, wr_data_q[i]);
        check_image("header_slots", 0, 0);
    endtask

    task automatic test_back_to_back();
        clear_writes();
        make_block(0, 1'b0);
        make_block(1, 1'b0);
        send_block(0);
        send_block(1);
        wait_writes("back_to_back", 2 * `BLOCK_BEATS);
        check_image("back_to_back", 0, 0);
        check_image("back_to_back", 1, `BLOCK_BEATS);
    endtask

    task automatic test_three_blocks();
        clear_writes();
        stall_cnt = 0;
        for (int b = 0; b < MAX_BLOCKS; b++)
            make_block(b, 1'b0);
        for (int b = 0; b < MAX_BLOCKS; b++)
            send_block(b);
        wait_writes("three_blocks", MAX_BLOCKS * `BLOCK_BEATS);
        for (int b = 0; b < MAX_BLOCKS; b++)
            check_image("three_blocks", b, b * `BLOCK_BEATS);
        $display("three_blocks: %0d input stall cycles", stall_cnt);
    endtask

    initial
    begin
        rst         = 1'b1;
        i_valid     = 1'b0;
        i_sop       = 1'b0;
        i_eop       = 1'b0;
        i_ant0_data = '0;
        i_ant1_data = '0;
        i_ant2_data = '0;
        i_ant3_data = '0;
        drive_header('0);
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        test_reset_state();
        test_ramp_block();
        test_header_slots();
        test_back_to_back();
        test_three_blocks();

        $display("Test OK");
        $finish;
    end

endmodule

//--- design/package_data_top.sv
`timescale 1ns/1ns
`include "package_data_defs.svh"

module package_data_top
(
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         i_valid,
    output logic                         o_ready,
    input  logic                         i_sop,
    input  logic                         i_eop,
    input  logic [`SAMPLE_W-1:0]         i_ant0_data,
    input  logic [`SAMPLE_W-1:0]         i_ant1_data,
    input  logic [`SAMPLE_W-1:0]         i_ant2_data,
    input  logic [`SAMPLE_W-1:0]         i_ant3_data,
    input  logic [3:0]                   i_ch_type,
    input  logic                         i_cell_idx,
    input  logic [6:0]                   i_slot_idx,
    input  logic [3:0]                   i_sym_idx,
    input  logic [8:0]                   i_prb_idx,
    input  logic [`NUM_ANT*`SHIFT_W-1:0] i_shift,
    output logic                         o_cpri_wen,
    output logic [`BEAT_IDX_W-1:0]       o_cpri_waddr,
    output logic [`WORD_W-1:0]           o_cpri_wdata,
    output logic                         o_cpri_wlast
);

    blk_rd_if u_rd_if ();
    pack_if   u_pk_if ();

    // antenna 0 in the low bits of each beat
    block_buffer u_block_buffer
    (
        .clk        (clk),
        .rst        (rst),
        .i_valid    (i_valid),
        .i_sop      (i_sop),
        .i_eop      (i_eop),
        .i_samples  ({i_ant3_data, i_ant2_data, i_ant1_data, i_ant0_data}),
        .i_ch_type  (i_ch_type),
        .i_cell_idx (i_cell_idx),
        .i_slot_idx (i_slot_idx),
        .i_sym_idx  (i_sym_idx),
        .i_prb_idx  (i_prb_idx),
        .i_shift    (i_shift),
        .o_ready    (o_ready),
        .rd         (u_rd_if.source)
    );

    sample_packer u_sample_packer
    (
        .clk (clk),
        .rst (rst),
        .rd  (u_rd_if.sink),
        .pk  (u_pk_if.source)
    );

    cpri_writer u_cpri_writer
    (
        .clk          (clk),
        .rst          (rst),
        .pk           (u_pk_if.sink),
        .o_cpri_wen   (o_cpri_wen),
        .o_cpri_waddr (o_cpri_waddr),
        .o_cpri_wdata (o_cpri_wdata),
        .o_cpri_wlast (o_cpri_wlast)
    );

endmodule

//--- design/cpri_writer.sv
`timescale 1ns/1ns
`include "package_data_defs.svh"

module cpri_writer
(
    input  logic                   clk,
    input  logic                   rst,
    pack_if.sink                   pk,
    output logic                   o_cpri_wen,
    output logic [`BEAT_IDX_W-1:0] o_cpri_waddr,
    output logic [`WORD_W-1:0]     o_cpri_wdata,
    output logic                   o_cpri_wlast
);

    import package_data_pkg::*;

    localparam logic [`BEAT_IDX_W-1:0]  ADDR_FIRST = `BEAT_IDX_W'(`DATA_ADDR_FIRST);
    localparam logic [`BEAT_IDX_W-1:0]  ADDR_LAST  = `BEAT_IDX_W'(`DATA_ADDR_LAST);
    localparam logic [`BEAT_IDX_W-1:0]  DATA_WORDS =
        `BEAT_IDX_W'(`DATA_ADDR_LAST - `DATA_ADDR_FIRST + 1);
    localparam logic [`GROUP_IDX_W-1:0] HEAD_GROUP = `GROUP_IDX_W'(`HEADER_SLOT);
    localparam logic [`GROUP_IDX_W-1:0] LAST_GROUP = `GROUP_IDX_W'(`NUM_GROUPS - 1);

    logic [`BEAT_IDX_W-1:0] slot_addr;
    logic [`BEAT_IDX_W-1:0] data_addr;
    cpri_word_u             wdata_q;

    // ----------------------------------------------------------------------
    // address map
    // ----------------------------------------------------------------------

    // groups 0..6 below the data area, 7..11 above it
    always_comb
    begin
        slot_addr = `BEAT_IDX_W'(pk.group);
        if (slot_addr >= ADDR_FIRST)
            slot_addr = slot_addr + DATA_WORDS;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            o_cpri_wen   <= 1'b0;
            o_cpri_wlast <= 1'b0;
            data_addr    <= ADDR_FIRST;
        end
        else
        begin
            o_cpri_wen   <= pk.valid;
            o_cpri_wlast <= pk.valid && !pk.slot && (pk.group == LAST_GROUP)
                            && (data_addr == ADDR_LAST);
            // realign on every block start
            if (pk.valid && pk.slot && (pk.group == '0))
                data_addr <= ADDR_FIRST;
            else if (pk.valid && !pk.slot)
                data_addr <= data_addr + `BEAT_IDX_W'(1);
        end
    end

    // ----------------------------------------------------------------------
    // write data, header goes out on the slot word of its group
    // ----------------------------------------------------------------------

    always_ff @(posedge clk)
    begin
        if (pk.valid)
        begin
            if (pk.slot)
            begin
                o_cpri_waddr <= slot_addr;
                wdata_q.head <= (pk.group == HEAD_GROUP) ? pk.header : '0;
            end
            else
            begin
                o_cpri_waddr <= data_addr;
                wdata_q      <= pk.word;
            end
        end
    end

    assign o_cpri_wdata = wdata_q;

    // data words must stay between the two slot areas
    assert property (@(posedge clk) disable iff (rst)
        (pk.valid && !pk.slot) |-> (data_addr >= ADDR_FIRST && data_addr <= ADDR_LAST));

endmodule

//--- design/sample_packer.sv
`timescale 1ns/1ns
`include "package_data_defs.svh"

module sample_packer
(
    input  logic    clk,
    input  logic    rst,
    blk_rd_if.sink  rd,
    pack_if.source  pk
);

    localparam int                      BEAT_W        = $clog2(`GROUP_BEATS);
    localparam logic [BEAT_W-1:0]       LAST_IN_GROUP = BEAT_W'(`GROUP_BEATS - 1);
    localparam logic [`GROUP_IDX_W-1:0] LAST_GROUP    = `GROUP_IDX_W'(`NUM_GROUPS - 1);

    logic [BEAT_W-1:0]                  beat_cnt;
    logic [`GROUP_IDX_W-1:0]            group_cnt;
    logic [`NUM_ANT-1:0][`SAMPLE_W-1:0] prev_samples;
    logic                               xfer;

    // eight 14-bit samples make seven 16-bit lanes
    // each beat takes 2 more bits from the current sample
    function automatic logic [`LANE_W-1:0] pack_lane(
        input logic [`SAMPLE_W-1:0] cur,
        input logic [`SAMPLE_W-1:0] prev,
        input logic [BEAT_W-1:0]    beat
    );
        logic [2*`SAMPLE_W-1:0] pair;
        logic [BEAT_W-1:0]      step;
        pair = {cur, prev};
        step = beat - BEAT_W'(1);
        if (beat == '0)
            return '0;
        pair = pair >> ((`LANE_W - `SAMPLE_W) * step);
        return pair[`LANE_W-1:0];
    endfunction

    assign rd.ready = 1'b1;
    assign xfer     = rd.valid && rd.ready;

    // ----------------------------------------------------------------------
    // beat and group position within the block
    // ----------------------------------------------------------------------

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            beat_cnt  <= '0;
            group_cnt <= '0;
            pk.valid  <= 1'b0;
        end
        else
        begin
            pk.valid <= xfer;
            if (xfer)
            begin
                if (beat_cnt == LAST_IN_GROUP)
                begin
                    beat_cnt  <= '0;
                    group_cnt <= (group_cnt == LAST_GROUP) ? '0 : group_cnt + `GROUP_IDX_W'(1);
                end
                else
                    beat_cnt <= beat_cnt + BEAT_W'(1);
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (xfer)
        begin
            prev_samples <= rd.samples;
            pk.slot      <= (beat_cnt == '0);
            pk.group     <= group_cnt;
            pk.header    <= rd.header;
            for (int a = 0; a < `NUM_ANT; a++)
                pk.word.lanes[a] <= pack_lane(rd.samples[a], prev_samples[a], beat_cnt);
        end
    end

    // the writer has no back-pressure so a block must stream unbroken
    assert property (@(posedge clk) disable iff (rst)
        (xfer && !(beat_cnt == LAST_IN_GROUP && group_cnt == LAST_GROUP)) |=> rd.valid);

endmodule

//--- design/block_buffer.sv
`timescale 1ns/1ns
`include "package_data_defs.svh"

module block_buffer
(
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               i_valid,
    input  logic                               i_sop,
    input  logic                               i_eop,
    input  logic [`NUM_ANT-1:0][`SAMPLE_W-1:0] i_samples,
    input  logic [3:0]                         i_ch_type,
    input  logic                               i_cell_idx,
    input  logic [6:0]                         i_slot_idx,
    input  logic [3:0]                         i_sym_idx,
    input  logic [8:0]                         i_prb_idx,
    input  logic [`NUM_ANT*`SHIFT_W-1:0]       i_shift,
    output logic                               o_ready,
    blk_rd_if.source                           rd
);

    import package_data_pkg::*;

    localparam logic [`BEAT_IDX_W-1:0] LAST_BEAT = `BEAT_IDX_W'(`BLOCK_BEATS - 1);

    logic [`NUM_ANT-1:0][`SAMPLE_W-1:0] bank_mem [2][`BLOCK_BEATS];
    block_header_t                      bank_hdr [2];
    logic [1:0]                         bank_full;

    logic                               wr_bank;
    logic [`BEAT_IDX_W-1:0]             wr_beat;
    logic                               wr_en;
    block_header_t                      in_hdr;

    logic                               rd_bank;
    logic [`BEAT_IDX_W-1:0]             rd_addr;
    logic                               can_load;
    logic                               fetch;

    // ----------------------------------------------------------------------
    // write side
    // ----------------------------------------------------------------------

    // stall only when the next bank to fill still holds a block
    assign o_ready = !bank_full[wr_bank];
    assign wr_en   = i_valid && o_ready;

    always_comb
    begin
        in_hdr          = '0;
        in_hdr.ch_type  = i_ch_type;
        in_hdr.cell_idx = i_cell_idx;
        in_hdr.slot_idx = i_slot_idx;
        in_hdr.sym_idx  = i_sym_idx;
        in_hdr.prb_idx  = i_prb_idx;
        in_hdr.shift    = i_shift;
    end

    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            bank_mem[wr_bank][wr_beat] <= i_samples;
            // header fields only valid on beat 0
            if (i_sop)
                bank_hdr[wr_bank] <= in_hdr;
        end
    end

    // ----------------------------------------------------------------------
    // read sequencer, one cycle memory latency into the output register
    // ----------------------------------------------------------------------

    assign can_load = !rd.valid || rd.ready;
    assign fetch    = can_load && bank_full[rd_bank];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wr_bank   <= 1'b0;
            wr_beat   <= '0;
            rd_bank   <= 1'b0;
            rd_addr   <= '0;
            bank_full <= '0;
        end
        else
        begin
            // bank is free once its last beat has left the memory
            if (fetch)
            begin
                if (rd_addr == LAST_BEAT)
                begin
                    rd_addr            <= '0;
                    rd_bank            <= !rd_bank;
                    bank_full[rd_bank] <= 1'b0;
                end
                else
                    rd_addr <= rd_addr + `BEAT_IDX_W'(1);
            end

            if (wr_en)
            begin
                if (wr_beat == LAST_BEAT)
                begin
                    wr_beat            <= '0;
                    wr_bank            <= !wr_bank;
                    bank_full[wr_bank] <= 1'b1;
                end
                else
                    wr_beat <= wr_beat + `BEAT_IDX_W'(1);
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (fetch)
        begin
            rd.samples <= bank_mem[rd_bank][rd_addr];
            if (rd_addr == '0)
                rd.header <= bank_hdr[rd_bank];
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            rd.valid <= 1'b0;
        else if (can_load)
            rd.valid <= fetch;
    end

    // framing from the source must agree with the beat counter
    assert property (@(posedge clk) disable iff (rst)
        wr_en |-> (i_sop == (wr_beat == '0)));

    assert property (@(posedge clk) disable iff (rst)
        wr_en |-> (i_eop == (wr_beat == LAST_BEAT)));

endmodule

//--- design/package_data_if.sv
`timescale 1ns/1ns
`include "package_data_defs.svh"

// block stream from the ping-pong buffer into the packer
interface blk_rd_if;
    import package_data_pkg::*;

    logic                               valid;
    logic                               ready;
    logic [`NUM_ANT-1:0][`SAMPLE_W-1:0] samples;
    block_header_t                      header;

    modport source (
        output valid,
        output samples,
        output header,
        input  ready
    );

    modport sink (
        input  valid,
        input  samples,
        input  header,
        output ready
    );
endinterface

// packed words into the cpri writer, always accepted
interface pack_if;
    import package_data_pkg::*;

    logic                    valid;
    logic                    slot;
    logic [`GROUP_IDX_W-1:0] group;
    cpri_word_u              word;
    block_header_t           header;

    modport source (output valid, output slot, output group, output word, output header);
    modport sink   (input  valid, input  slot, input  group, input  word, input  header);
endinterface

//--- design/package_data_pkg.sv
`include "package_data_defs.svh"

package package_data_pkg;

    // fields below the padding
    localparam int HEAD_USED_W = 4 + 1 + 7 + 4 + 9 + `NUM_ANT * `SHIFT_W;
    localparam int HEAD_PAD_W  = `WORD_W - HEAD_USED_W;

    // header word, top down as it lands in the cpri buffer
    typedef struct packed {
        logic [HEAD_PAD_W-1:0]             pad;
        logic [3:0]                        ch_type;
        logic                              cell_idx;
        logic [6:0]                        slot_idx;
        logic [3:0]                        sym_idx;
        logic [8:0]                        prb_idx;
        // antenna 3 in the top nibble
        logic [`NUM_ANT-1:0][`SHIFT_W-1:0] shift;
    } block_header_t;

    // one cpri word, either the header or four packed lanes
    typedef union packed {
        block_header_t                     head;
        logic [`NUM_ANT-1:0][`LANE_W-1:0]  lanes;
    } cpri_word_u;

endpackage

//--- design/package_data_defs.svh
`ifndef PACKAGE_DATA_DEFS_SVH
`define PACKAGE_DATA_DEFS_SVH

// sample and lane geometry
`define SAMPLE_W        14
`define LANE_W          16
`define NUM_ANT         4
`define SHIFT_W         4
`define WORD_W          64

// block framing
`define BLOCK_BEATS     96
`define BEAT_IDX_W      7
`define GROUP_BEATS     8
`define NUM_GROUPS      12
`define GROUP_IDX_W     4

// cpri buffer address map
`define DATA_ADDR_FIRST 7
`define DATA_ADDR_LAST  90
`define HEADER_SLOT     3

`endif
